/* egress_sched.f */
logic/egress_sched_pkg.sv
logic/desc_fifo.sv
logic/queue_store.sv
logic/prio_arbiter.sv
logic/dequeue_engine.sv
logic/egress_port_buf.sv
logic/egress_sched_top.sv
test/egress_sched_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the egress scheduler testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module egress_sched_tb \
    -f egress_sched.f -o egress_sched_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/egress_sched_sim)
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

/* test/egress_sched_tb.sv */
//////////////////////////////
// Egress scheduler testbench
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module egress_sched_tb
    import egress_sched_pkg::*;
();

    localparam int TBL_N  = 24;
    localparam int RND_N  = 60;
    localparam int MARGIN = 4000;
    // Longer than any gap between words of a busy port
    localparam int QUIET_CYCLES = 32;

    // Enqueue table
    // Queue 3 gets one entry more than it holds
    localparam int TBL_QID [TBL_N] = '{0, 1, 2, 4, 5, 7, 6, 8, 11, 10, 12, 15,
                                       13, 0, 3, 3, 3, 3, 3, 3, 3, 3, 3, 14};
    localparam int TBL_LEN [TBL_N] = '{100, 1500, 65, 500, 64, 191, 192, 640, 300, 64, 1000, 65,
                                       128, 77, 64, 200, 300, 64, 128, 129, 256, 70, 999, 1499};

    logic                  core_clk_ifc;
    logic                  rst_n;
    logic                  enq_valid;
    qid_t                  enq_qid;
    pkt_len_t              enq_len;
    logic [NUM_PORTS-1:0]  port_enable;
    logic [NUM_QUEUES-1:0] queue_empty;
    logic [NUM_QUEUES-1:0] queue_full;
    logic [NUM_PORTS-1:0]  out_valid;
    word_bytes_t           out_bytes [NUM_PORTS];
    logic [NUM_PORTS-1:0]  out_last;
    prio_t                 out_prio [NUM_PORTS];

    // Reference model
    // One length queue per DUT queue
    int mq_len [NUM_QUEUES][128];
    int mq_rd [NUM_QUEUES];
    int mq_wr [NUM_QUEUES];
    int packets_pushed;
    int packets_seen;

    // Output tracking per port
    logic [NUM_PORTS-1:0] pkt_active;
    logic [NUM_PORTS-1:0] have_prev;
    int pkt_prio [NUM_PORTS];
    int pkt_rem [NUM_PORTS];
    int prev_cycle [NUM_PORTS];
    int prev_cost [NUM_PORTS];
    int cycle;

    int          errors;
    int          checks;
    logic        check_order;
    logic [31:0] lcg_state;
    int          rnd_qid [RND_N];
    int          rnd_len [RND_N];
    int          rnd_gap [RND_N];
    int          limit_cycles;
    logic        limit_ready;

    egress_sched_top dut_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .enq_valid    (enq_valid),
        .enq_qid      (enq_qid),
        .enq_len      (enq_len),
        .port_enable  (port_enable),
        .queue_empty  (queue_empty),
        .queue_full   (queue_full),
        .out_valid    (out_valid),
        .out_bytes    (out_bytes),
        .out_last     (out_last),
        .out_prio     (out_prio)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    //////////////////////////////
    // Helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int range);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:16]) % range;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic record_packet(input int qid, input int len);
        mq_len[qid][mq_wr[qid]] = len;
        mq_wr[qid]++;
        packets_pushed++;
    endtask

    // Highest non-empty modelled queue of a port
    // Returns -1 when there is none
    function automatic int top_prio(input int p);
        int best;
        best = -1;
        for (int q = 0; q < QUEUES_PER_PORT; q++) begin
            if (mq_wr[p * QUEUES_PER_PORT + q] != mq_rd[p * QUEUES_PER_PORT + q]) begin
                best = q;
            end
        end
        return best;
    endfunction

    function automatic logic [NUM_QUEUES-1:0] empty_mask();
        logic [NUM_QUEUES-1:0] mask;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            mask[q] = (mq_wr[q] == mq_rd[q]);
        end
        return mask;
    endfunction

    task automatic enqueue(input int qid, input int len);
        enq_valid = 1'b1;
        enq_qid   = qid_t'(qid);
        enq_len   = pkt_len_t'(len);
        @(posedge core_clk_ifc);
        #1;
        enq_valid = 1'b0;
    endtask

    // Idle once no port has sent a word for a while
    task automatic wait_drain();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(posedge core_clk_ifc);
            #1;
            quiet = (out_valid != '0) ? 0 : quiet + 1;
        end
    endtask

    //////////////////////////////
    // Output monitor
    always @(negedge core_clk_ifc) begin
        int qidx;
        int exp_bytes;
        int min_gap;
        int gap;
        int cost;
        if (!rst_n) begin
            cycle        = 0;
            pkt_active   = '0;
            have_prev    = '0;
            packets_seen = 0;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                mq_rd[q] = 0;
            end
        end else begin
            cycle = cycle + 1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_valid[p]) begin
                    cost = 0;
                    if (!pkt_active[p]) begin
                        qidx = p * QUEUES_PER_PORT + int'(out_prio[p]);
                        if (check_order) begin
                            check_value($sformatf("out_prio[%0d] at packet start", p),
                                        int'(out_prio[p]), top_prio(p));
                        end
                        if (mq_wr[qidx] == mq_rd[qidx]) begin
                            errors++;
                            $display("Word on port %0d at %0t ns with no packet queued for it",
                                     p, $time);
                        end else begin
                            pkt_active[p] = 1'b1;
                            pkt_prio[p]   = int'(out_prio[p]);
                            pkt_rem[p]    = mq_len[qidx][mq_rd[qidx]];
                        end
                    end else begin
                        // Same queue from first word to last
                        check_value($sformatf("out_prio[%0d] inside packet", p),
                                    int'(out_prio[p]), pkt_prio[p]);
                    end
                    if (pkt_active[p]) begin
                        exp_bytes = (pkt_rem[p] > WORD_BYTES) ? WORD_BYTES : pkt_rem[p];
                        check_value($sformatf("out_bytes[%0d]", p), int'(out_bytes[p]), exp_bytes);
                        check_value($sformatf("out_last[%0d]", p), int'(out_last[p]),
                                    (pkt_rem[p] <= WORD_BYTES) ? 1 : 0);
                        cost = exp_bytes + ((pkt_rem[p] <= WORD_BYTES) ? ETH_OVERHEAD : 0);
                        pkt_rem[p] = pkt_rem[p] - exp_bytes;
                        if (pkt_rem[p] == 0) begin
                            qidx = p * QUEUES_PER_PORT + pkt_prio[p];
                            mq_rd[qidx]++;
                            packets_seen++;
                            pkt_active[p] = 1'b0;
                        end
                    end
                    if (have_prev[p]) begin
                        gap     = cycle - prev_cycle[p];
                        min_gap = (prev_cost[p] + SHAPER_DEC - 1) / SHAPER_DEC;
                        // Clamped, so only a gap below the minimum shows up
                        check_value($sformatf("out_valid[%0d] spacing", p),
                                    (gap < min_gap) ? gap : min_gap, min_gap);
                    end
                    have_prev[p]  = 1'b1;
                    prev_cycle[p] = cycle;
                    prev_cost[p]  = cost;
                end
            end
        end
    end

    //////////////////////////////
    // Watchdog
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge core_clk_ifc);
        $display("Timeout after %0d cycles, %0d of %0d packets seen",
                 limit_cycles, packets_seen, packets_pushed);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    initial begin
        int  q;
        int  total;
        logic full_exp;
        rst_n          = 1'b0;
        enq_valid      = 1'b0;
        enq_qid        = '0;
        enq_len        = '0;
        port_enable    = '0;
        errors         = 0;
        checks         = 0;
        check_order    = 1'b1;
        packets_pushed = 0;
        limit_ready    = 1'b0;
        lcg_state      = 32'h40083d79;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            mq_wr[i] = 0;
        end

        // Random entries are drawn up front so the time limit covers them
        total = 0;
        for (int i = 0; i < TBL_N; i++) begin
            total += TBL_LEN[i];
        end
        for (int i = 0; i < RND_N; i++) begin
            rnd_qid[i] = rand_below(NUM_QUEUES);
            rnd_len[i] = MIN_PKT_BYTES + rand_below(MTU_BYTES - MIN_PKT_BYTES + 1);
            rnd_gap[i] = rand_below(8);
            total += rnd_len[i];
        end
        limit_cycles = total * 2 / SHAPER_DEC + MARGIN;
        limit_ready  = 1'b1;

        repeat (8) @(posedge core_clk_ifc);
        #1;
        rst_n = 1'b1;
        check_value("queue_empty after reset", int'(queue_empty), int'(empty_mask()));

        // Load the table with all ports stopped
        for (int i = 0; i < TBL_N; i++) begin
            q        = TBL_QID[i];
            full_exp = (mq_wr[q] - mq_rd[q] >= QUEUE_DEPTH);
            check_value($sformatf("queue_full[%0d]", q), int'(queue_full[q]), int'(full_exp));
            if (!full_exp) begin
                record_packet(q, TBL_LEN[i]);
            end
            enqueue(q, TBL_LEN[i]);
        end
        check_value("queue_empty after load", int'(queue_empty), int'(empty_mask()));
        for (int i = 0; i < NUM_QUEUES; i++) begin
            check_value($sformatf("queue_full[%0d] after load", i), int'(queue_full[i]),
                        (mq_wr[i] - mq_rd[i] >= QUEUE_DEPTH) ? 1 : 0);
        end

        port_enable = '1;
        wait_drain();
        check_value("queue_empty after table", int'(queue_empty), int'({NUM_QUEUES{1'b1}}));
        check_value("packets seen after table", packets_seen, packets_pushed);
        check_order = 1'b0;

        // Random enqueues while the ports run
        // Two ports pause for a while
        for (int i = 0; i < RND_N; i++) begin
            if (i == 20) begin
                port_enable[1] = 1'b0;
                port_enable[3] = 1'b0;
            end
            if (i == 40) begin
                port_enable = '1;
            end
            repeat (rnd_gap[i]) begin
                @(posedge core_clk_ifc);
                #1;
            end
            while (queue_full[rnd_qid[i]]) begin
                // A paused port has to drain before its queue takes more
                port_enable = '1;
                @(posedge core_clk_ifc);
                #1;
            end
            record_packet(rnd_qid[i], rnd_len[i]);
            enqueue(rnd_qid[i], rnd_len[i]);
        end
        port_enable = '1;
        wait_drain();

        check_value("queue_empty at end", int'(queue_empty), int'({NUM_QUEUES{1'b1}}));
        check_value("packets in progress at end", int'(pkt_active), 0);
        check_value("packets seen", packets_seen, packets_pushed);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/egress_sched_top.sv */
//////////////////////////////
// Egress scheduler top
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module egress_sched_top
    import egress_sched_pkg::*;
(
    input  wire logic                 core_clk_ifc,
    input  wire logic                 rst_n,
    input  wire logic                 enq_valid,
    input  wire qid_t                 enq_qid,
    input  wire pkt_len_t             enq_len,
    input  wire logic [NUM_PORTS-1:0] port_enable,
    output logic [NUM_QUEUES-1:0]     queue_empty,
    output logic [NUM_QUEUES-1:0]     queue_full,
    output logic [NUM_PORTS-1:0]      out_valid,
    output word_bytes_t               out_bytes [NUM_PORTS],
    output logic [NUM_PORTS-1:0]      out_last,
    output prio_t                     out_prio [NUM_PORTS]
);

    logic                 req_valid;
    qid_t                 req_qid;
    qid_t                 head_qid;
    pkt_len_t             head_len;
    logic                 pop_valid;
    qid_t                 pop_qid;
    logic                 done_valid;
    port_t                done_port;
    logic                 done_last;
    logic                 wr_valid;
    port_t                wr_port;
    word_bytes_t          wr_bytes;
    logic                 wr_last;
    prio_t                wr_prio;
    logic [NUM_PORTS-1:0] buf_ready;

    queue_store queue_store_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .enq_valid    (enq_valid),
        .enq_qid      (enq_qid),
        .enq_len      (enq_len),
        .head_qid     (head_qid),
        .head_len     (head_len),
        .pop_valid    (pop_valid),
        .pop_qid      (pop_qid),
        .queue_empty  (queue_empty),
        .queue_full   (queue_full)
    );

    prio_arbiter prio_arbiter_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .queue_empty  (queue_empty),
        .port_enable  (port_enable),
        .buf_ready    (buf_ready),
        .done_valid   (done_valid),
        .done_port    (done_port),
        .done_last    (done_last),
        .req_valid    (req_valid),
        .req_qid      (req_qid)
    );

    dequeue_engine dequeue_engine_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_qid      (req_qid),
        .head_qid     (head_qid),
        .head_len     (head_len),
        .pop_valid    (pop_valid),
        .pop_qid      (pop_qid),
        .done_valid   (done_valid),
        .done_port    (done_port),
        .done_last    (done_last),
        .wr_valid     (wr_valid),
        .wr_port      (wr_port),
        .wr_bytes     (wr_bytes),
        .wr_last      (wr_last),
        .wr_prio      (wr_prio)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        egress_port_buf port_buf_i (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .wr_valid     (wr_valid && (wr_port == port_t'(p))),
            .wr_bytes     (wr_bytes),
            .wr_last      (wr_last),
            .wr_prio      (wr_prio),
            .buf_ready    (buf_ready[p]),
            .out_valid    (out_valid[p]),
            .out_bytes    (out_bytes[p]),
            .out_last     (out_last[p]),
            .out_prio     (out_prio[p])
        );
    end

endmodule

`default_nettype wire

/* logic/egress_port_buf.sv */
//////////////////////////////
// Egress buffer and shaper
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module egress_port_buf
    import egress_sched_pkg::*;
(
    input  wire logic        core_clk_ifc,
    input  wire logic        rst_n,
    input  wire logic        wr_valid,
    input  wire word_bytes_t wr_bytes,
    input  wire logic        wr_last,
    input  wire prio_t       wr_prio,
    output logic             buf_ready,
    output logic             out_valid,
    output word_bytes_t      out_bytes,
    output logic             out_last,
    output prio_t            out_prio
);

    localparam int FILL_W = $clog2(BUF_DEPTH + 1);

    typedef logic [$bits(prio_t)+$bits(word_desc_t)-1:0] buf_item_t;

    buf_item_t  push_item;
    buf_item_t  head;
    word_desc_t wr_desc;
    word_desc_t head_desc;
    logic       empty;
    logic       full;
    logic       send;

    logic [FILL_W-1:0] fill;
    credit_t           credit;

    assign wr_desc   = {wr_last, wr_bytes};
    assign push_item = {wr_prio, wr_desc};

    desc_fifo #(
        .item_t (buf_item_t),
        .DEPTH  (BUF_DEPTH)
    ) word_fifo_i (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .push         (wr_valid),
        .push_item    (push_item),
        .pop          (send),
        .head         (head),
        .empty        (empty),
        .full         (full)
    );

    assign {out_prio, head_desc} = head;
    assign out_last  = head_desc[$bits(word_desc_t)-1];
    assign out_bytes = head_desc[$bits(word_bytes_t)-1:0];

    //////////////////////////////
    // Back-pressure
    // Room for the words that may still be in the pipeline
    assign buf_ready = (FILL_W'(BUF_DEPTH) - fill) >= FILL_W'(BUF_SLACK);

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
        end else begin
            case ({wr_valid, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    //////////////////////////////
    // Byte-credit shaper
    assign send      = !empty && (credit == '0);
    assign out_valid = send;

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            credit <= '0;
        end else if (send) begin
            // Interframe gap and preamble after the packet
            credit <= credit_t'(out_bytes) + (out_last ? credit_t'(ETH_OVERHEAD) : '0);
        end else if (credit > credit_t'(SHAPER_DEC)) begin
            credit <= credit - credit_t'(SHAPER_DEC);
        end else begin
            credit <= '0;
        end
    end

    // Arbiter slack must cover every word still in flight
    assert property (@(posedge core_clk_ifc) disable iff (!rst_n) wr_valid |-> !full);

endmodule

`default_nettype wire

/* logic/dequeue_engine.sv */
//////////////////////////////
// Two-stage dequeue engine
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dequeue_engine
    import egress_sched_pkg::*;
(
    input  wire logic     core_clk_ifc,
    input  wire logic     rst_n,
    input  wire logic     req_valid,
    input  wire qid_t     req_qid,
    output qid_t          head_qid,
    input  wire pkt_len_t head_len,
    output logic          pop_valid,
    output qid_t          pop_qid,
    output logic          done_valid,
    output port_t         done_port,
    output logic          done_last,
    output logic          wr_valid,
    output port_t         wr_port,
    output word_bytes_t   wr_bytes,
    output logic          wr_last,
    output prio_t         wr_prio
);

    logic  s1_valid;
    qid_t  s1_qid;
    port_t s1_port;

    // Bytes still to cut from the packet in progress per port
    logic [NUM_PORTS-1:0] in_prog;
    pkt_len_t             rem [NUM_PORTS];

    pkt_len_t    cur_len;
    logic        cur_last;
    word_bytes_t cur_bytes;

    //////////////////////////////
    // Stage 1
    assign s1_port  = qid_port(s1_qid);
    assign head_qid = s1_qid;

    assign cur_len   = in_prog[s1_port] ? rem[s1_port] : head_len;
    assign cur_last  = (cur_len <= pkt_len_t'(WORD_BYTES));
    assign cur_bytes = cur_last ? word_bytes_t'(cur_len) : word_bytes_t'(WORD_BYTES);

    // Descriptor leaves the queue with its last word
    assign pop_valid = s1_valid && cur_last;
    assign pop_qid   = s1_qid;

    assign done_valid = s1_valid;
    assign done_port  = s1_port;
    assign done_last  = cur_last;

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            in_prog  <= '0;
            wr_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            wr_valid <= s1_valid;
            if (s1_valid) begin
                in_prog[s1_port] <= !cur_last;
            end
        end
    end

    //////////////////////////////
    // Stage 2
    always_ff @(posedge core_clk_ifc) begin
        if (req_valid) begin
            s1_qid <= req_qid;
        end
        if (s1_valid) begin
            // Meaningless after the last word, in_prog ignores it
            rem[s1_port] <= cur_len - pkt_len_t'(WORD_BYTES);
            wr_port      <= s1_port;
            wr_bytes     <= cur_bytes;
            wr_last      <= cur_last;
            wr_prio      <= qid_prio(s1_qid);
        end
    end

endmodule

`default_nettype wire

/* logic/prio_arbiter.sv */
//////////////////////////////
// Strict-priority arbiter
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module prio_arbiter
    import egress_sched_pkg::*;
(
    input  wire logic                  core_clk_ifc,
    input  wire logic                  rst_n,
    input  wire logic [NUM_QUEUES-1:0] queue_empty,
    input  wire logic [NUM_PORTS-1:0]  port_enable,
    input  wire logic [NUM_PORTS-1:0]  buf_ready,
    input  wire logic                  done_valid,
    input  wire port_t                 done_port,
    input  wire logic                  done_last,
    output logic                       req_valid,
    output qid_t                       req_qid
);

    logic [NUM_PORTS-1:0] lock_valid;
    logic [NUM_PORTS-1:0] in_flight;
    logic [NUM_PORTS-1:0] has_work;
    logic [NUM_PORTS-1:0] eligible;
    prio_t                lock_prio [NUM_PORTS];
    prio_t                pick_prio [NUM_PORTS];

    port_t last_port;
    port_t grant_port;
    logic  grant;

    //////////////////////////////
    // Queue choice per port
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            has_work[p]  = lock_valid[p];
            pick_prio[p] = lock_prio[p];
            if (!lock_valid[p]) begin
                // Ascending scan, so the highest non-empty queue wins
                for (int q = 0; q < QUEUES_PER_PORT; q++) begin
                    if (!queue_empty[p * QUEUES_PER_PORT + q]) begin
                        has_work[p]  = 1'b1;
                        pick_prio[p] = prio_t'(q);
                    end
                end
            end
            eligible[p] = port_enable[p] && buf_ready[p] && !in_flight[p] && has_work[p];
        end
    end

    //////////////////////////////
    // Port rotation
    always_comb begin
        port_t cand;
        grant      = 1'b0;
        grant_port = last_port;
        // Nearest port after the last one served is checked last and wins
        for (int i = NUM_PORTS; i >= 1; i--) begin
            cand = last_port + port_t'(i);
            if (eligible[cand]) begin
                grant      = 1'b1;
                grant_port = cand;
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            req_valid  <= 1'b0;
            lock_valid <= '0;
            in_flight  <= '0;
            last_port  <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                lock_prio[p] <= '0;
            end
        end else begin
            req_valid <= grant;
            if (grant) begin
                in_flight[grant_port]  <= 1'b1;
                lock_valid[grant_port] <= 1'b1;
                lock_prio[grant_port]  <= pick_prio[grant_port];
                last_port              <= grant_port;
            end
            if (done_valid) begin
                in_flight[done_port] <= 1'b0;
                if (done_last) begin
                    lock_valid[done_port] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (grant) begin
            req_qid <= {grant_port, pick_prio[grant_port]};
        end
    end

    // Pop only comes with the last word, so every request finds a head
    assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        req_valid |-> !queue_empty[req_qid]);

endmodule

`default_nettype wire

/* logic/queue_store.sv */
//////////////////////////////
// Per-queue length store
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module queue_store
    import egress_sched_pkg::*;
(
    input  wire logic     core_clk_ifc,
    input  wire logic     rst_n,
    input  wire logic     enq_valid,
    input  wire qid_t     enq_qid,
    input  wire pkt_len_t enq_len,
    input  wire qid_t     head_qid,
    output pkt_len_t      head_len,
    input  wire logic     pop_valid,
    input  wire qid_t     pop_qid,
    output logic [NUM_QUEUES-1:0] queue_empty,
    output logic [NUM_QUEUES-1:0] queue_full
);

    pkt_len_t heads [NUM_QUEUES];

    logic [NUM_QUEUES-1:0] push;
    logic [NUM_QUEUES-1:0] pop;

    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        // Enqueue to a full queue is dropped here
        assign push[q] = enq_valid && (enq_qid == qid_t'(q)) && !queue_full[q];
        assign pop[q]  = pop_valid && (pop_qid == qid_t'(q));

        desc_fifo #(
            .item_t (pkt_len_t),
            .DEPTH  (QUEUE_DEPTH)
        ) len_fifo_i (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .push         (push[q]),
            .push_item    (enq_len),
            .pop          (pop[q]),
            .head         (heads[q]),
            .empty        (queue_empty[q]),
            .full         (queue_full[q])
        );
    end

    // Head length of the queue in stage 1
    assign head_len = heads[head_qid];

endmodule

`default_nettype wire

/* logic/desc_fifo.sv */
//////////////////////////////
// Descriptor FIFO
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module desc_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  wire logic  core_clk_ifc,
    input  wire logic  rst_n,
    input  wire logic  push,
    input  wire item_t push_item,
    input  wire logic  pop,
    output item_t      head,
    output logic       empty,
    output logic       full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Callers gate their strobes with the flags
    assert property (@(posedge core_clk_ifc) disable iff (!rst_n) !(push && full));
    assert property (@(posedge core_clk_ifc) disable iff (!rst_n) !(pop && empty));

endmodule

`default_nettype wire

/* logic/egress_sched_pkg.sv */
//////////////////////////////
// Egress scheduler package
//////////////////////////////
`default_nettype none

package egress_sched_pkg;

    //////////////////////////////
    // Sizes
    localparam int NUM_PORTS       = 4;
    // Highest index is the highest priority
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT;
    localparam int QUEUE_DEPTH     = 8;

    localparam int WORD_BYTES    = 64;
    localparam int MTU_BYTES     = 1500;
    localparam int MIN_PKT_BYTES = 64;

    localparam int BUF_DEPTH = 8;
    // Two pipeline stages plus one
    localparam int BUF_SLACK = 3;

    //////////////////////////////
    // Shaper
    localparam int SHAPER_DEC   = 8;
    localparam int ETH_OVERHEAD = 20;

    //////////////////////////////
    // Types
    typedef logic [$clog2(NUM_QUEUES)-1:0]      qid_t;
    typedef logic [$clog2(NUM_PORTS)-1:0]       port_t;
    typedef logic [$clog2(QUEUES_PER_PORT)-1:0] prio_t;
    typedef logic [$clog2(MTU_BYTES+1)-1:0]     pkt_len_t;
    typedef logic [$clog2(WORD_BYTES+1)-1:0]    word_bytes_t;

    // Last flag on top of the byte count
    typedef logic [$bits(word_bytes_t):0] word_desc_t;

    typedef logic [$clog2(WORD_BYTES+ETH_OVERHEAD+1)-1:0] credit_t;

    // Port in the upper bits of a queue number
    function automatic port_t qid_port(qid_t qid);
        return qid[$bits(qid_t)-1 -: $bits(port_t)];
    endfunction

    function automatic prio_t qid_prio(qid_t qid);
        return qid[$bits(prio_t)-1:0];
    endfunction

endpackage

`default_nettype wire
